//--- flist.f
+incdir+test
src/sme_cfg_pkg.sv
src/aes_op_pkg.sv
src/sme_aes_ctrl.sv
src/sme_sbox_masked.sv
src/sme_aes_mixcol.sv
src/sme_aes_top.sv
test/sme_aes_tb.sv

//--- test/aes_model.svh
// Unmasked AES reference for the testbench; build_sbox_tables must run before any lookup
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// Lookup tables ----------------------------------
logic [7:0] sbox_tab     [256];          // Forward S-box
logic [7:0] inv_sbox_tab [256];          // Filled by inverting the forward table

// Multiply by x, poly x^8+x^4+x^3+x+1
function automatic logic [7:0] xtime(input logic [7:0] a);
    return a[7] ? ((a << 1) ^ 8'h1b) : (a << 1);
endfunction

function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p   = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) acc ^= p;
        p = xtime(p);
    end
    return acc;
endfunction

// Inverse by search, then the affine map bit by bit
function automatic void build_sbox_tables();
    logic [7:0] inv;
    logic [7:0] s;
    for (int a = 0; a < 256; a++) begin
        inv = 8'h00;                     // Zero maps to zero
        for (int b = 1; b < 256; b++) begin
            if (gmul(a[7:0], b[7:0]) == 8'h01) inv = b[7:0];
        end
        for (int i = 0; i < 8; i++) begin
            s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
                 ^ inv[(i + 7) % 8];
        end
        s = s ^ 8'h63;                   // Affine constant
        sbox_tab[a]     = s;
        inv_sbox_tab[s] = a[7:0];
    end
endfunction

// Column for one S-box byte, top byte first
function automatic logic [31:0] model_column(input logic [7:0] s, input logic dec,
                                             input logic mix);
    if (!mix) return {24'h0, s};
    if (dec)  return {gmul(s, 8'h0b), gmul(s, 8'h0d), gmul(s, 8'h09), gmul(s, 8'h0e)};
    return {gmul(s, 8'h03), s, s, xtime(s)};
endfunction

function automatic logic [31:0] rot_left_bytes(input logic [31:0] w, input logic [1:0] n);
    logic [63:0] dbl;
    dbl = {w, w} << (8 * n);             // Upper half is the rotated word
    return dbl[63:32];
endfunction

// aes32 on plain operands
function automatic logic [31:0] model_aes32(input logic [31:0] rs1, input logic [31:0] rs2,
                                            input logic [1:0] bs, input logic dec,
                                            input logic mix);
    logic [7:0] s;
    s = dec ? inv_sbox_tab[rs2[8*bs +: 8]] : sbox_tab[rs2[8*bs +: 8]];
    return rs1 ^ rot_left_bytes(model_column(s, dec, mix), bs);
endfunction

`endif

//--- test/sme_aes_tb.sv
`timescale 1ns/10ps
// Same stimulus drives a 3-share and a 2-share DUT; req is held low after each ack until idle
module sme_aes_tb
    import sme_cfg_pkg::*, aes_op_pkg::*;
#(
    parameter int N_OPS = 300                  // Random operations
);

    `include "aes_model.svh"

    localparam int RESET_CYCLES   = 16;
    localparam int OP_CYCLES      = 36;        // Worst case per op with an aborted try
    localparam int TIMEOUT_CYCLES = N_OPS * OP_CYCLES + RESET_CYCLES + 200;

    logic        g_clk;
    logic        reset;
    logic        req;
    aes_req_t    req_data;
    share_byte_t rng;
    logic        flush;
    logic        ack;
    logic        ack_ns2;
    aes_rsp_t    rsp;
    aes_rsp_t    rsp_ns2;
    logic [31:0] rand_state;
    int          value_errors;
    int          protocol_errors;

    sme_aes_top #(.NSHARES(3)) dut_i (
        .g_clk(g_clk), .reset(reset), .req(req), .req_data(req_data),
        .rng(rng), .flush(flush), .ack(ack), .rsp(rsp)
    );

    sme_aes_top #(.NSHARES(2)) dut_ns2_i (
        .g_clk(g_clk), .reset(reset), .req(req), .req_data(req_data),
        .rng(rng), .flush(flush), .ack(ack_ns2), .rsp(rsp_ns2)
    );

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;             // 8 ns period
    end

    // Stimulus and model --------------------------
    function automatic logic [31:0] next_rand();
        rand_state = rand_state ^ (rand_state << 13);
        rand_state = rand_state ^ (rand_state >> 17);
        rand_state = rand_state ^ (rand_state << 5);
        return rand_state;
    endfunction

    task automatic make_req(output aes_req_t r, output share_byte_t g);
        logic [31:0] w;
        for (int i = 0; i < MAX_SHARES; i++) begin
            r.rs1[i] = next_rand();            // Dead lanes get junk too
            r.rs2[i] = next_rand();
        end
        g = next_rand();
        w = next_rand();
        r.dec = w[0];
        r.mix = w[1];
        r.bs  = w[3:2];
    endtask

    // Share 0 carries the S-box value under the masks and shares 1.. the rng bytes
    function automatic aes_rsp_t expect_rsp(input int ns, input aes_req_t r,
                                            input share_byte_t g, output share_byte_t sb);
        logic [31:0] rs2c;
        logic [7:0]  mask;
        aes_rsp_t    e;
        rs2c = '0;
        mask = 8'h00;
        sb   = '0;
        e    = '0;
        for (int i = 0; i < ns; i++) rs2c ^= r.rs2[i];
        for (int i = 1; i < ns; i++) begin
            sb[i] = g[i];
            mask ^= g[i];
        end
        sb[0] = mask ^ (r.dec ? inv_sbox_tab[rs2c[8*r.bs +: 8]] : sbox_tab[rs2c[8*r.bs +: 8]]);
        for (int i = 0; i < ns; i++) begin
            e.rd[i] = r.rs1[i] ^ rot_left_bytes(model_column(sb[i], r.dec, r.mix), r.bs);
        end
        return e;
    endfunction

    // Compare tasks --------------------------------
    task automatic check_rsp(input string name, input aes_rsp_t got, input aes_rsp_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got %h expected %h", name, got.rd, exp.rd);
        end
    endtask

    task automatic check_byte_share(input string name, input share_byte_t got,
                                    input share_byte_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_dut(input int ns, input aes_rsp_t got, input share_byte_t sb_got,
                             input aes_req_t r, input share_byte_t g);
        aes_rsp_t    exp;
        share_byte_t sb_exp;
        logic [31:0] rs1c;
        logic [31:0] rs2c;
        logic [31:0] rdc;
        exp  = expect_rsp(ns, r, g, sb_exp);
        rs1c = '0;
        rs2c = '0;
        rdc  = '0;
        for (int i = 0; i < ns; i++) begin
            rs1c ^= r.rs1[i];
            rs2c ^= r.rs2[i];
            rdc  ^= got.rd[i];
        end
        check_word($sformatf("rd recombined (%0d shares)", ns), rdc,
                   model_aes32(rs1c, rs2c, r.bs, r.dec, r.mix));
        check_byte_share($sformatf("sbox_out (%0d shares)", ns), sb_got, sb_exp);
        check_rsp($sformatf("rsp (%0d shares)", ns), got, exp);
    endtask

    // Handshake driver -----------------------------
    task automatic run_op(input aes_req_t r, input share_byte_t g, input int hold);
        int       lat;
        aes_rsp_t held;
        aes_rsp_t held_ns2;
        @(posedge g_clk);
        req      <= 1'b1;
        req_data <= r;
        rng      <= g;
        @(posedge g_clk);                      // Edge 0 takes this rng
        rng <= next_rand();                    // Later bytes must not reach the masks
        lat = 0;
        @(negedge g_clk);
        while (!ack && lat < 16) begin
            @(negedge g_clk);
            lat++;
        end
        if (lat != 4) begin
            protocol_errors++;
            $display("ack rose %0d cycles after the req sample, expected 4", lat);
        end
        if (ack_ns2 !== ack) begin
            protocol_errors++;
            $display("ack of the 2-share DUT does not follow the 3-share DUT");
        end
        check_dut(3, rsp, dut_i.i_sbox.sbox_out, r, g);
        check_dut(2, rsp_ns2, dut_ns2_i.i_sbox.sbox_out, r, g);
        held     = rsp;
        held_ns2 = rsp_ns2;
        repeat (hold) begin                    // Back-pressure
            @(negedge g_clk);
            if (!ack || !ack_ns2) begin
                protocol_errors++;
                $display("ack dropped while req was still high");
            end
            check_rsp("rsp under back-pressure", rsp, held);
            check_rsp("rsp_ns2 under back-pressure", rsp_ns2, held_ns2);
        end
        @(posedge g_clk);
        req <= 1'b0;
        @(negedge g_clk);
        if (!ack || !ack_ns2) begin
            protocol_errors++;
            $display("ack fell in the same cycle as req");
        end
        @(negedge g_clk);
        if (ack || ack_ns2) begin
            protocol_errors++;
            $display("ack still high one cycle after req fell");
        end
    endtask

    // Start a run and abort it k cycles later
    task automatic abort_op(input aes_req_t r, input share_byte_t g, input int k);
        @(posedge g_clk);
        req      <= 1'b1;
        req_data <= r;
        rng      <= g;
        repeat (k) @(posedge g_clk);
        flush <= 1'b1;
        req   <= 1'b0;                         // Requester backs off with the flush
        @(posedge g_clk);
        flush <= 1'b0;
        repeat (8) begin
            @(negedge g_clk);
            if (ack || ack_ns2) begin
                protocol_errors++;
                $display("ack raised for a flushed request");
            end
        end
    endtask

    // Watchdog -------------------------------------
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge g_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not complete", cycles);
        $display("Test failures found");
        $finish;
    end

    // Main sequence --------------------------------
    initial begin : main
        aes_req_t    r;
        share_byte_t g;
        logic [31:0] w;
        reset           = 1'b1;
        req             = 1'b0;
        req_data        = '0;
        rng             = '0;
        flush           = 1'b0;
        rand_state      = 32'd55173;
        value_errors    = 0;
        protocol_errors = 0;
        build_sbox_tables();
        if (sbox_tab[8'h00] != 8'h63 || sbox_tab[8'h53] != 8'hed ||
            inv_sbox_tab[8'h00] != 8'h52) begin
            value_errors++;
            $display("Reference S-box table does not match the known AES values");
        end
        repeat (RESET_CYCLES) @(posedge g_clk);
        reset <= 1'b0;
        for (int n = 0; n < N_OPS; n++) begin
            make_req(r, g);
            w = next_rand();
            if (w[2:0] == 3'd0) abort_op(r, g, 1 + w[4:3]);   // About one op in eight
            run_op(r, g, w[31:8] % 11);
        end
        repeat (4) @(posedge g_clk);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- src/sme_aes_top.sv
`timescale 1ns/10ps
// Fixed four-cycle latency from req sample to ack; NSHARES from MIN_SHARES to MAX_SHARES only
module sme_aes_top
    import sme_cfg_pkg::*, aes_op_pkg::*;
#(
    parameter int NSHARES = 3            // Live share lanes
)(
    input  logic        g_clk,
    input  logic        reset,
    input  logic        req,
    input  aes_req_t    req_data,
    input  share_byte_t rng,             // Random bytes, sampled on accept
    input  logic        flush,
    output logic        ack,
    output aes_rsp_t    rsp
);

    aes_req_t    op;                     // Captured request
    logic        sbox_load;
    logic        res_load;
    share_byte_t sbox_out;

    // Share-count range check at elaboration
    if (NSHARES < MIN_SHARES || NSHARES > MAX_SHARES) begin : g_bad_nshares
        $error("NSHARES out of range");
    end

    // Control ---------------------------------------
    sme_aes_ctrl #(
        .NSHARES   (NSHARES)
    ) i_ctrl (
        .g_clk     (g_clk),
        .reset     (reset),
        .req       (req),
        .req_data  (req_data),
        .flush     (flush),
        .ack       (ack),
        .op        (op),
        .sbox_load (sbox_load),
        .res_load  (res_load)
    );

    // Datapath --------------------------------------
    sme_sbox_masked #(
        .NSHARES   (NSHARES)
    ) i_sbox (
        .g_clk     (g_clk),
        .reset     (reset),
        .load      (sbox_load),
        .rng       (rng),
        .op        (op),
        .sbox_out  (sbox_out)
    );

    sme_aes_mixcol #(
        .NSHARES   (NSHARES)
    ) i_mixcol (
        .g_clk     (g_clk),
        .reset     (reset),
        .load      (res_load),
        .op        (op),
        .sbox_out  (sbox_out),
        .rsp       (rsp)
    );

endmodule

//--- src/sme_aes_mixcol.sv
`timescale 1ns/10ps
// Linear back end, works share by share; lanes at or above NSHARES read zero
module sme_aes_mixcol
    import sme_cfg_pkg::*, aes_op_pkg::*;
#(
    parameter int NSHARES = 3            // Live share lanes
)(
    input  logic        g_clk,
    input  logic        reset,
    input  logic        load,            // Result strobe, edge 3
    input  aes_req_t    op,              // Captured operands
    input  share_byte_t sbox_out,        // Masked S-box byte
    output aes_rsp_t    rsp
);

    share_word_t rd_next;

    // Multiply by a 4-bit constant in GF(2^8)
    function automatic logic [7:0] gf_mulc(input logic [7:0] a, input logic [3:0] c);
        logic [7:0] acc;
        logic [7:0] pa;
        acc = 8'h00;
        pa  = a;
        for (int i = 0; i < 4; i++) begin
            if (c[i]) acc = acc ^ pa;
            pa = {pa[6:0], 1'b0} ^ (pa[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    // Rotate left by whole bytes
    function automatic logic [31:0] rotl_bytes(input logic [31:0] w, input byte_sel_t n);
        case (n)
            2'd0:    return w;
            2'd1:    return {w[23:0], w[31:24]};
            2'd2:    return {w[15:0], w[31:16]};
            default: return {w[7:0],  w[31:8]};
        endcase
    endfunction

    // Column expansion --------------------------------
    always_comb begin : p_col
        logic [7:0]  s;
        logic [31:0] col;
        rd_next = '0;                    // Dead lanes stay zero
        for (int i = 0; i < NSHARES; i++) begin
            s = sbox_out[i];
            if (!op.mix)
                col = {24'h0, s};
            else if (op.dec)
                col = {gf_mulc(s, 4'd11), gf_mulc(s, 4'd13), gf_mulc(s, 4'd9), gf_mulc(s, 4'd14)};
            else
                col = {gf_mulc(s, 4'd3), s, s, gf_mulc(s, 4'd2)};
            rd_next[i] = rotl_bytes(col, op.bs) ^ op.rs1[i];
        end
    end

    // Result register, held through ack
    always_ff @(posedge g_clk) begin
        if (reset) begin
            rsp <= '0;
        end else if (load) begin
            rsp.rd <= rd_next;
        end
    end

endmodule

//--- src/sme_sbox_masked.sv
`timescale 1ns/10ps
// Reference S-box only: shares are recombined in the clear, so no side-channel protection
module sme_sbox_masked
    import sme_cfg_pkg::*, aes_op_pkg::*;
#(
    parameter int NSHARES = 3            // Live share lanes
)(
    input  logic        g_clk,
    input  logic        reset,
    input  logic        load,            // Accept pulse from control
    input  share_byte_t rng,             // Fresh random bytes, lane 0 unused
    input  aes_req_t    op,              // Captured operands
    output share_byte_t sbox_out         // Re-masked S-box byte
);

    logic        stage1;                 // Recombine step pending
    logic        stage2;                 // S-box step pending
    share_byte_t rng_keep;               // rng with lane 0 and dead lanes cleared
    share_byte_t rng_q;                  // Masks taken at accept
    logic [7:0]  byte_mix;               // Recombined rs2 byte
    logic [7:0]  byte_q;
    logic [7:0]  sbox_val;               // Unmasked S-box result
    logic [7:0]  mask;                   // XOR of the new masks
    share_byte_t sbox_next;

    // GF(2^8) helpers -------------------------------
    // Poly x^8+x^4+x^3+x+1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] pa;
        acc = 8'h00;
        pa  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) acc = acc ^ pa;
            pa = {pa[6:0], 1'b0} ^ (pa[7] ? 8'h1b : 8'h00);   // xtime
        end
        return acc;
    endfunction

    // a^254, which also maps 0 to 0
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] p;
        logic [7:0] r;
        p = a;
        r = 8'h01;
        for (int i = 1; i < 8; i++) begin
            p = gf_mul(p, p);            // a^(2^i)
            r = gf_mul(r, p);
        end
        return r;
    endfunction

    function automatic logic [7:0] rotl8(input logic [7:0] a, input int n);
        return (a << n) | (a >> (8 - n));
    endfunction

    // Forward affine map, constant 0x63
    function automatic logic [7:0] fwd_affine(input logic [7:0] a);
        return a ^ rotl8(a, 1) ^ rotl8(a, 2) ^ rotl8(a, 3) ^ rotl8(a, 4) ^ 8'h63;
    endfunction

    // Inverse affine map, constant 0x05
    function automatic logic [7:0] inv_affine(input logic [7:0] a);
        return rotl8(a, 1) ^ rotl8(a, 3) ^ rotl8(a, 6) ^ 8'h05;
    endfunction

    // Datapath --------------------------------------
    always_comb begin
        byte_mix = 8'h00;
        rng_keep = '0;
        for (int i = 0; i < NSHARES; i++) begin
            byte_mix = byte_mix ^ op.rs2[i][{op.bs, 3'b000} +: 8];  // Pick byte bs
            if (i > 0) rng_keep[i] = rng[i];
        end
    end

    assign sbox_val = op.dec ? gf_inv(inv_affine(byte_q)) : fwd_affine(gf_inv(byte_q));

    always_comb begin
        mask = 8'h00;
        for (int i = 0; i < MAX_SHARES; i++) begin
            mask = mask ^ rng_q[i];      // Cleared lanes add nothing
        end
        sbox_next    = rng_q;            // Shares 1.. are the masks themselves
        sbox_next[0] = sbox_val ^ mask;
    end

    // Stage tracking, edge 1 then edge 2
    always_ff @(posedge g_clk) begin
        if (reset) begin
            stage1 <= 1'b0;
            stage2 <= 1'b0;
        end else begin
            stage1 <= load;
            stage2 <= stage1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (load)   rng_q    <= rng_keep;    // Edge 0
        if (stage1) byte_q   <= byte_mix;    // Edge 1
        if (stage2) sbox_out <= sbox_next;   // Edge 2
    end

endmodule

//--- src/sme_aes_ctrl.sv
`timescale 1ns/10ps
// Four-phase req/ack, one request in flight; req_data must be stable while req is high
module sme_aes_ctrl
    import sme_cfg_pkg::*, aes_op_pkg::*;
#(
    parameter int NSHARES = 3            // Live share lanes
)(
    input  logic     g_clk,
    input  logic     reset,
    input  logic     req,                // Requester strobe
    input  aes_req_t req_data,           // Operands, sampled on accept
    input  logic     flush,              // Abort, no ack
    output logic     ack,                // rsp valid
    output aes_req_t op,                 // Captured operands
    output logic     sbox_load,          // Accept pulse, rng capture
    output logic     res_load            // Result register strobe
);

    // FSM states
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_RUN     = 2'd1;
    localparam logic [1:0] ST_DONE    = 2'd2;
    localparam logic [1:0] ST_RELEASE = 2'd3;

    logic [1:0] state;
    logic [1:0] step;                    // Pipeline step within run
    logic       accept;                  // Request taken this cycle
    aes_req_t   req_trim;                // Request with dead lanes cleared

    // Strobes ---------------------------------------
    assign accept    = (state == ST_IDLE) && req && !flush;
    assign sbox_load = accept;                                       // Edge 0
    assign res_load  = (state == ST_RUN) && (step == 2'd2) && !flush; // Edge 3
    assign ack       = (state == ST_DONE);                           // From edge 4

    // Lanes past NSHARES forced to zero on the way in
    always_comb begin
        req_trim = req_data;
        for (int i = NSHARES; i < MAX_SHARES; i++) begin
            req_trim.rs1[i] = '0;
            req_trim.rs2[i] = '0;
        end
    end

    // FSM and step counter --------------------------
    always_ff @(posedge g_clk) begin
        if (reset || flush) begin
            state <= ST_IDLE;            // Flush drops any run or ack
            step  <= 2'd0;
        end else begin
            case (state)
                ST_IDLE: begin
                    step <= 2'd0;
                    if (req) state <= ST_RUN;
                end
                ST_RUN: begin
                    step <= step + 2'd1;                  // 0..3, wraps on exit
                    if (step == 2'd3) state <= ST_DONE;
                end
                ST_DONE: if (!req) state <= ST_RELEASE;   // Hold ack for req
                ST_RELEASE: if (!req) state <= ST_IDLE;   // ack low, wait quiet req
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Operand register, held until the next accept
    always_ff @(posedge g_clk) begin
        if (accept) op <= req_trim;
    end

endmodule

//--- src/aes_op_pkg.sv
// Request and result of one aes32 step; operands are share vectors from sme_cfg_pkg
package aes_op_pkg;

    import sme_cfg_pkg::*;

    // Byte position in rs2, also the rotation amount in bytes
    typedef logic [1:0] byte_sel_t;

    // Operation request ------------------------------
    // dec/mix together pick one of the four aes32 kinds:
    //   dec=0 mix=0  encrypt, S-box only
    //   dec=0 mix=1  encrypt with MixColumn
    //   dec=1 mix=0  decrypt, inverse S-box only
    //   dec=1 mix=1  decrypt with inverse MixColumn
    typedef struct packed {
        logic        dec;     // Inverse S-box / inverse column
        logic        mix;     // Expand by column coefficients
        byte_sel_t   bs;      // Byte select
        share_word_t rs1;     // Accumulator operand
        share_word_t rs2;     // Source of the S-box byte
    } aes_req_t;

    // Operation result -------------------------------
    typedef struct packed {
        share_word_t rd;      // rs1 XOR rotated column, per share
    } aes_rsp_t;

endpackage

//--- src/sme_cfg_pkg.sv
// Share vectors are always MAX_SHARES wide; lanes at or above the built share count carry zero
package sme_cfg_pkg;

    // Share-count limits ----------------------------
    localparam int MIN_SHARES = 2;    // Fewest shares a unit may be built with
    localparam int MAX_SHARES = 4;    // Width of every share vector on a port

    localparam int XLEN = 32;         // Scalar register width

    // Share vectors ---------------------------------
    // Lane 0 is the first share; recombined value is the XOR of the live lanes

    // One 32-bit operand as Boolean shares
    typedef logic [MAX_SHARES-1:0][XLEN-1:0] share_word_t;

    // One byte as Boolean shares, also used for the random byte vector
    typedef logic [MAX_SHARES-1:0][7:0] share_byte_t;

endpackage
